//--- Makefile
VERILATOR ?= verilator
TOP       ?= vcache_array_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SRCS    := $(shell cat $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	$(abspath $(SIM_BIN)) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/cmd_if.sv
interface cmd_if;
    import vcache_pkg::*;

    // one command per cycle of vld, no back-pressure
    logic       vld;
    opcode_t    opcode;
    block_id_t  block;
    chan_t      chan;
    word_addr_t addr;

    modport up (
        output vld,
        output opcode,
        output block,
        output chan,
        output addr
    );

    modport down (
        input vld,
        input opcode,
        input block,
        input chan,
        input addr
    );

endinterface

//--- hw/data_if.sv
interface data_if;
    import vcache_pkg::*;

    // write high marks data headed for a bank, low marks read data
    logic      vld;
    logic      write;
    block_id_t block;
    chan_t     chan;
    data_t     data;

    modport up (
        output vld,
        output write,
        output block,
        output chan,
        output data
    );

    modport down (
        input vld,
        input write,
        input block,
        input chan,
        input data
    );

endinterface

//--- hw/mem_block.sv
module mem_block #(
    parameter vcache_pkg::block_id_t BLOCK_ID = '0
) (
    input  logic clk,
    input  logic rst_n,
    cmd_if.down  cmd_w  [vcache_pkg::NUM_LANES],
    cmd_if.up    cmd_e  [vcache_pkg::NUM_LANES],
    data_if.down data_w [vcache_pkg::NUM_LANES],
    data_if.up   data_e [vcache_pkg::NUM_LANES]
);
    import vcache_pkg::*;

    // west side commands, decoded per lane
    logic       rd_hit    [NUM_LANES];
    logic       wr_hit    [NUM_LANES];
    chan_t      cmd_chan  [NUM_LANES];
    word_addr_t cmd_addr  [NUM_LANES];

    // west side data chain
    logic       din_vld   [NUM_LANES];
    logic       din_write [NUM_LANES];
    block_id_t  din_block [NUM_LANES];
    chan_t      din_chan  [NUM_LANES];
    data_t      din_data  [NUM_LANES];

    logic       rd_grant  [NUM_LANES];
    logic       rd_vld_d  [NUM_LANES];
    chan_t      rd_chan_d [NUM_LANES];
    logic       wr_vld_d  [NUM_LANES];
    chan_t      wr_chan_d [NUM_LANES];
    word_addr_t wr_addr_d [NUM_LANES];

    logic       bank_rd_en   [NUM_CHANS];
    word_addr_t bank_rd_addr [NUM_CHANS];
    data_t      bank_rd_data [NUM_CHANS];
    logic       bank_wr_en   [NUM_CHANS];
    word_addr_t bank_wr_addr [NUM_CHANS];
    data_t      bank_wr_data [NUM_CHANS];

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        // commands go east untouched
        assign cmd_e[l].vld    = cmd_w[l].vld;
        assign cmd_e[l].opcode = cmd_w[l].opcode;
        assign cmd_e[l].block  = cmd_w[l].block;
        assign cmd_e[l].chan   = cmd_w[l].chan;
        assign cmd_e[l].addr   = cmd_w[l].addr;

        assign rd_hit[l] = cmd_w[l].vld && cmd_w[l].opcode == OP_READ
                           && cmd_w[l].block == BLOCK_ID;
        assign wr_hit[l] = cmd_w[l].vld && cmd_w[l].opcode == OP_WRITE
                           && cmd_w[l].block == BLOCK_ID;
        assign cmd_chan[l] = cmd_w[l].chan;
        assign cmd_addr[l] = cmd_w[l].addr;

        assign din_vld[l]   = data_w[l].vld;
        assign din_write[l] = data_w[l].write;
        assign din_block[l] = data_w[l].block;
        assign din_chan[l]  = data_w[l].chan;
        assign din_data[l]  = data_w[l].data;

        // read data replaces the chain, own write data is taken off it
        always_comb begin
            if (rd_vld_d[l]) begin
                data_e[l].vld   = 1'b1;
                data_e[l].write = 1'b0;
                data_e[l].block = BLOCK_ID;
                data_e[l].chan  = rd_chan_d[l];
                data_e[l].data  = bank_rd_data[rd_chan_d[l]];
            end else begin
                data_e[l].vld   = din_vld[l] && !(din_write[l] && din_block[l] == BLOCK_ID);
                data_e[l].write = din_write[l];
                data_e[l].block = din_block[l];
                data_e[l].chan  = din_chan[l];
                data_e[l].data  = din_data[l];
            end
        end
    end

    // lane 0 first when two reads hit one bank
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            rd_grant[l] = rd_hit[l];
            for (int k = 0; k < l; k++) begin
                if (rd_hit[k] && cmd_chan[k] == cmd_chan[l]) begin
                    rd_grant[l] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                rd_vld_d[l] <= 1'b0;
                wr_vld_d[l] <= 1'b0;
            end
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                rd_vld_d[l] <= rd_grant[l];
                wr_vld_d[l] <= wr_hit[l];
            end
        end
    end

    // held write command lines up with its data
    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            rd_chan_d[l] <= cmd_chan[l];
            wr_chan_d[l] <= cmd_chan[l];
            wr_addr_d[l] <= cmd_addr[l];
        end
    end

    // bank port steering, lanes scanned high to low so lane 0 wins
    always_comb begin
        for (int b = 0; b < NUM_CHANS; b++) begin
            bank_rd_en[b]   = 1'b0;
            bank_rd_addr[b] = '0;
            bank_wr_en[b]   = 1'b0;
            bank_wr_addr[b] = '0;
            bank_wr_data[b] = '0;
            for (int l = NUM_LANES - 1; l >= 0; l--) begin
                if (rd_grant[l] && cmd_chan[l] == chan_t'(b)) begin
                    bank_rd_en[b]   = 1'b1;
                    bank_rd_addr[b] = cmd_addr[l];
                end
                if (wr_vld_d[l] && wr_chan_d[l] == chan_t'(b) && din_vld[l] && din_write[l]) begin
                    bank_wr_en[b]   = 1'b1;
                    bank_wr_addr[b] = wr_addr_d[l];
                    bank_wr_data[b] = din_data[l];
                end
            end
        end
    end

    for (genvar b = 0; b < NUM_CHANS; b++) begin : g_bank
        ram_bank bank_inst (
            .clk     (clk),
            .rd_en   (bank_rd_en[b]),
            .rd_addr (bank_rd_addr[b]),
            .rd_data (bank_rd_data[b]),
            .wr_en   (bank_wr_en[b]),
            .wr_addr (bank_wr_addr[b]),
            .wr_data (bank_wr_data[b])
        );
    end

endmodule

//--- hw/ram_bank.sv
module ram_bank (
    input  logic                   clk,
    input  logic                   rd_en,
    input  vcache_pkg::word_addr_t rd_addr,
    output vcache_pkg::data_t      rd_data,
    input  logic                   wr_en,
    input  vcache_pkg::word_addr_t wr_addr,
    input  vcache_pkg::data_t      wr_data
);
    import vcache_pkg::*;

    data_t mem [BANK_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, data valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- hw/req_sequencer.sv
module req_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_vld,
    input  logic                   req_write,
    input  vcache_pkg::host_addr_t req_addr,
    input  vcache_pkg::data_t      req_wdata,
    output logic                   req_ready,
    output logic                   rsp_vld,
    output vcache_pkg::data_t      rsp_rdata,
    cmd_if.up                      cmd,
    data_if.up                     wdata,
    data_if.down                   rdata
);
    import vcache_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;

    // latched request
    opcode_t    op_q;
    host_addr_t addr_q;
    data_t      wdata_q;
    data_t      rdata_q;

    block_id_t  req_block;
    chan_t      req_chan;
    word_addr_t req_word;

    assign {req_block, req_chan, req_word} = addr_q;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req_vld) begin
                    state_nxt = CMD;
                end
            end
            CMD: begin
                state_nxt = (op_q == OP_WRITE) ? WDATA : RDATA;
            end
            WDATA: state_nxt = IDLE;
            RDATA: state_nxt = RESP;
            RESP:  state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req_vld) begin
            op_q    <= req_write ? OP_WRITE : OP_READ;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
        // read data arrives at the east end in RDATA
        if (state == RDATA && rdata.vld && !rdata.write) begin
            rdata_q <= rdata.data;
        end
    end

    // command chain
    assign cmd.vld    = (state == CMD);
    assign cmd.opcode = op_q;
    assign cmd.block  = req_block;
    assign cmd.chan   = req_chan;
    assign cmd.addr   = req_word;

    // write data one cycle behind the command
    assign wdata.vld   = (state == WDATA);
    assign wdata.write = (state == WDATA);
    assign wdata.block = req_block;
    assign wdata.chan  = req_chan;
    assign wdata.data  = wdata_q;

    // host side
    assign req_ready = (state == IDLE);
    assign rsp_vld   = (state == RESP);
    assign rsp_rdata = rdata_q;

endmodule

//--- hw/vcache_array_top.sv
module vcache_array_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_vld   [vcache_pkg::NUM_LANES],
    input  logic                   req_write [vcache_pkg::NUM_LANES],
    input  vcache_pkg::host_addr_t req_addr  [vcache_pkg::NUM_LANES],
    input  vcache_pkg::data_t      req_wdata [vcache_pkg::NUM_LANES],
    output logic                   req_ready [vcache_pkg::NUM_LANES],
    output logic                   rsp_vld   [vcache_pkg::NUM_LANES],
    output vcache_pkg::data_t      rsp_rdata [vcache_pkg::NUM_LANES]
);
    import vcache_pkg::*;

    // chain segments: sequencer to block 0, block 0 to block 1, block 1 east end
    cmd_if  cmd_west  [NUM_LANES] ();
    cmd_if  cmd_mid   [NUM_LANES] ();
    cmd_if  cmd_east  [NUM_LANES] ();
    data_if data_west [NUM_LANES] ();
    data_if data_mid  [NUM_LANES] ();
    data_if data_east [NUM_LANES] ();

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        req_sequencer seq_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .req_vld   (req_vld[l]),
            .req_write (req_write[l]),
            .req_addr  (req_addr[l]),
            .req_wdata (req_wdata[l]),
            .req_ready (req_ready[l]),
            .rsp_vld   (rsp_vld[l]),
            .rsp_rdata (rsp_rdata[l]),
            .cmd       (cmd_west[l]),
            .wdata     (data_west[l]),
            // east end of the data chain loops back
            .rdata     (data_east[l])
        );
    end

    mem_block #(
        .BLOCK_ID (block_id_t'(0))
    ) block0_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .cmd_w  (cmd_west),
        .cmd_e  (cmd_mid),
        .data_w (data_west),
        .data_e (data_mid)
    );

    mem_block #(
        .BLOCK_ID (block_id_t'(1))
    ) block1_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .cmd_w  (cmd_mid),
        .cmd_e  (cmd_east),
        .data_w (data_mid),
        .data_e (data_east)
    );

endmodule

//--- hw/vcache_pkg.sv
package vcache_pkg;

    // array sizes
    localparam int NUM_LANES  = 2;
    localparam int NUM_BLOCKS = 2;
    localparam int NUM_CHANS  = 2;
    localparam int BANK_DEPTH = 64;

    // widths that carry a meaning
    typedef logic [$clog2(BANK_DEPTH)-1:0] word_addr_t;
    typedef logic [31:0]                   data_t;
    typedef logic [$clog2(NUM_BLOCKS)-1:0] block_id_t;
    typedef logic [$clog2(NUM_CHANS)-1:0]  chan_t;

    // block id on top, then channel, then word address
    localparam int HOST_ADDR_W = $bits(block_id_t) + $bits(chan_t) + $bits(word_addr_t);
    typedef logic [HOST_ADDR_W-1:0] host_addr_t;

    // chain opcodes
    typedef logic [0:0] opcode_t;
    localparam opcode_t OP_READ  = 1'b0;
    localparam opcode_t OP_WRITE = 1'b1;

    // request sequencer states
    typedef enum logic [2:0] {
        IDLE,
        CMD,
        WDATA,
        RDATA,
        RESP
    } seq_state_t;

endpackage

//--- sim/vcache_array_assert.sv
module vcache_array_assert #(
    parameter vcache_pkg::block_id_t BLOCK_ID = '0
) (
    input logic                                                 clk,
    input logic                                                 rst_n,
    input logic                                                 rd_hit   [vcache_pkg::NUM_LANES],
    input logic                                                 wr_hit   [vcache_pkg::NUM_LANES],
    input vcache_pkg::chan_t                                    cmd_chan [vcache_pkg::NUM_LANES],
    input logic [vcache_pkg::NUM_LANES-1:0]                     e_vld,
    input logic [vcache_pkg::NUM_LANES-1:0]                     e_write,
    input vcache_pkg::block_id_t [vcache_pkg::NUM_LANES-1:0]    e_block
);
    timeunit 1ns;
    timeprecision 100ps;
    import vcache_pkg::*;

    // number of failed assertions in this block
    int unsigned fails = 0;

    // host keeps two lanes off one bank in the same cycle
    read_clash: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_hit[0] && rd_hit[1] && cmd_chan[0] == cmd_chan[1]))
    else begin
        $error("two lanes read bank %0d of block %0d in one cycle", cmd_chan[0], BLOCK_ID);
        fails++;
    end

    write_clash: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_hit[0] && wr_hit[1] && cmd_chan[0] == cmd_chan[1]))
    else begin
        $error("two lanes write bank %0d of block %0d in one cycle", cmd_chan[0], BLOCK_ID);
        fails++;
    end

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        // write data for this block or any block further west never goes east of here
        own_write_absorbed: assert property (@(posedge clk) disable iff (!rst_n)
            !(e_vld[l] && e_write[l] && e_block[l] <= BLOCK_ID))
        else begin
            $error("write data for block %0d left block %0d on lane %0d",
                   e_block[l], BLOCK_ID, l);
            fails++;
        end
    end

endmodule

bind mem_block vcache_array_assert #(
    .BLOCK_ID (BLOCK_ID)
) assert_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_hit   (rd_hit),
    .wr_hit   (wr_hit),
    .cmd_chan (cmd_chan),
    .e_vld    ({data_e[1].vld, data_e[0].vld}),
    .e_write  ({data_e[1].write, data_e[0].write}),
    .e_block  ({data_e[1].block, data_e[0].block})
);

//--- sim/vcache_array_tb.sv
module vcache_array_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import vcache_pkg::*;

    localparam int TIMEOUT    = 20;
    localparam int NUM_RANDOM = 200;
    localparam int BANK_W     = $bits(block_id_t) + $bits(chan_t);

    logic       clk;
    logic       rst_n;
    logic       req_vld   [NUM_LANES];
    logic       req_write [NUM_LANES];
    host_addr_t req_addr  [NUM_LANES];
    data_t      req_wdata [NUM_LANES];
    logic       req_ready [NUM_LANES];
    logic       rsp_vld   [NUM_LANES];
    data_t      rsp_rdata [NUM_LANES];

    // reference model over the whole host address space
    data_t model [2**HOST_ADDR_W];
    bit    known [2**HOST_ADDR_W];

    integer seed = 32'ha82332c3;
    int     checks;
    int     errors;

    vcache_array_top vcache_array_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_vld   (req_vld),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .rsp_vld   (rsp_vld),
        .rsp_rdata (rsp_rdata)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $finish;
    endtask

    task automatic check_word(input string name, input int lane, input data_t got,
                              input data_t exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %s[%0d] got %h expected %h", name, lane, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        $display("%s done, %0d errors", name, errors - errs_before);
    endtask

    // enters and leaves 1 ns after an edge, leaves with req_ready high
    task automatic wait_ready(input int lane);
        int n;
        n = 0;
        while (req_ready[lane] !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (req_ready[lane] !== 1'b1) begin
            abort_run($sformatf("timeout waiting for req_ready on lane %0d", lane));
        end
    endtask

    // returns in the first cycle after acceptance
    task automatic issue(input int lane, input logic write, input host_addr_t addr,
                         input data_t wdata);
        wait_ready(lane);
        req_vld[lane]   = 1'b1;
        req_write[lane] = write;
        req_addr[lane]  = addr;
        req_wdata[lane] = wdata;
        @(posedge clk);
        #1;
        req_vld[lane] = 1'b0;
    endtask

    task automatic do_write(input int lane, input host_addr_t addr, input data_t data);
        issue(lane, 1'b1, addr, data);
        model[addr] = data;
        known[addr] = 1'b1;
        wait_ready(lane);
    endtask

    // lat counts cycles from acceptance to rsp_vld
    task automatic do_read(input int lane, input host_addr_t addr, output int lat);
        int n;
        issue(lane, 1'b0, addr, '0);
        n = 1;
        while (rsp_vld[lane] !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (rsp_vld[lane] !== 1'b1) begin
            abort_run($sformatf("no read response on lane %0d for address %h", lane, addr));
        end else begin
            check_word("rsp_rdata", lane, rsp_rdata[lane], model[addr]);
            lat = n;
        end
    endtask

    task automatic run_request(input int lane, input logic write, input host_addr_t addr,
                               input data_t data);
        int lat;
        if (write) begin
            do_write(lane, addr, data);
        end else begin
            do_read(lane, addr, lat);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        for (int l = 0; l < NUM_LANES; l++) begin
            check_word("req_ready", l, data_t'(req_ready[l]), 32'h1);
            check_word("rsp_vld", l, data_t'(rsp_vld[l]), 32'h0);
        end
        finish_test("reset", e0);
    endtask

    task automatic test_write_read();
        int e0;
        int lat;
        host_addr_t addr;
        e0 = errors;
        // one address in each of the four banks
        for (int b = 0; b < NUM_BLOCKS * NUM_CHANS; b++) begin
            addr = host_addr_t'(b * BANK_DEPTH + b * 9 + 3);
            do_write(0, addr, 32'hc0de_0000 + data_t'(b));
            do_read(0, addr, lat);
        end
        finish_test("write then read on lane 0", e0);
    endtask

    task automatic test_read_latency();
        int e0;
        int lat;
        e0 = errors;
        do_write(1, 8'h55, 32'h1234_abcd);
        do_read(1, 8'h55, lat);
        check_word("rsp_vld cycles", 1, data_t'(lat), 32'd3);
        check_word("req_ready", 1, data_t'(req_ready[1]), 32'h0);
        @(posedge clk);
        #1;
        check_word("req_ready", 1, data_t'(req_ready[1]), 32'h1);
        check_word("rsp_vld", 1, data_t'(rsp_vld[1]), 32'h0);
        finish_test("read latency", e0);
    endtask

    task automatic test_cross_lane();
        int e0;
        int lat0;
        int lat1;
        e0 = errors;
        // lane 0 hits block 0 channel 1 and lane 1 hits block 1 channel 0
        fork
            do_write(0, 8'h4a, 32'h0a0a_1111);
            do_write(1, 8'h8a, 32'h1b1b_2222);
        join
        fork
            do_read(0, 8'h8a, lat0);
            do_read(1, 8'h4a, lat1);
        join
        finish_test("shared storage across lanes", e0);
    endtask

    task automatic test_isolation();
        int e0;
        int lat;
        e0 = errors;
        do_write(0, 8'h27, 32'haaaa_0001);
        do_write(1, 8'ha7, 32'hbbbb_0002);
        do_read(1, 8'h27, lat);
        do_read(0, 8'ha7, lat);
        finish_test("block isolation", e0);
    endtask

    task automatic test_random();
        int e0;
        host_addr_t a [NUM_LANES];
        logic       w [NUM_LANES];
        data_t      d [NUM_LANES];
        e0 = errors;
        for (int r = 0; r < NUM_RANDOM / NUM_LANES; r++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                a[l] = host_addr_t'($random(seed));
                w[l] = 1'($random(seed));
                d[l] = data_t'($random(seed));
            end
            // keep lane 1 off lane 0's bank
            if (a[1][HOST_ADDR_W-1 -: BANK_W] == a[0][HOST_ADDR_W-1 -: BANK_W]) begin
                a[1][$bits(word_addr_t)] = ~a[1][$bits(word_addr_t)];
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                if (!w[l] && !known[a[l]]) begin
                    w[l] = 1'b1;
                end
            end
            fork
                run_request(0, w[0], a[0], d[0]);
                run_request(1, w[1], a[1], d[1]);
            join
        end
        finish_test("random traffic", e0);
    endtask

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        checks = 0;
        errors = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            req_vld[l]   = 1'b0;
            req_write[l] = 1'b0;
            req_addr[l]  = '0;
            req_wdata[l] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset();
        test_write_read();
        test_read_latency();
        test_cross_lane();
        test_isolation();
        test_random();

        // failures of the bound checkers
        errors += vcache_array_top_inst.block0_inst.assert_inst.fails;
        errors += vcache_array_top_inst.block1_inst.assert_inst.fails;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/vcache_pkg.sv
hw/cmd_if.sv
hw/data_if.sv
hw/ram_bank.sv
hw/mem_block.sv
hw/req_sequencer.sv
hw/vcache_array_top.sv
sim/vcache_array_assert.sv
sim/vcache_array_tb.sv
